/* cache_bus_pkg.sv */
package cache_bus_pkg;

    // Access size as sent by the CPU
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        BYTE    = 2'd1,
        HALF    = 2'd2,
        WORD    = 2'd3
    } access_size_e;

    typedef struct packed {
        cache_geom_pkg::cpu_addr_u addr;
        logic                      write;   // 1 for a store
        access_size_e              size;
        cache_geom_pkg::word_t     wdata;   // Right-aligned store data
    } cpu_req_t;

    typedef struct packed {
        cache_geom_pkg::word_t rdata;       // Zero-extended load data
    } cpu_resp_t;

    // One line per transfer
    typedef struct packed {
        logic                                      write;
        logic [cache_geom_pkg::LINE_ADDR_BITS-1:0] line_addr;
        cache_geom_pkg::line_t                     wline;
    } mem_req_t;

    typedef struct packed {
        cache_geom_pkg::line_t rline;       // Don't care on write acks
    } mem_resp_t;

endpackage

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cpu_req_valid,
    input  cache_bus_pkg::cpu_req_t              cpu_req,
    output logic                                 cpu_resp_valid,
    output cache_bus_pkg::cpu_resp_t             cpu_resp,
    output logic                                 busy,
    output logic                                 mem_req_valid,
    output cache_bus_pkg::mem_req_t              mem_req,
    input  logic                                 mem_resp_valid,
    input  cache_bus_pkg::mem_resp_t             mem_resp,
    output logic [cache_geom_pkg::INDEX_BITS-1:0] rd_index,
    output cache_bus_pkg::cpu_req_t              cur_req,
    output logic                                 store_en,
    output logic                                 fill_en,
    output cache_geom_pkg::line_t                fill_line,
    input  cache_geom_pkg::line_t                bank_line,
    input  cache_geom_pkg::word_t                load_word
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_WAIT,     // Write-back in flight
        ST_FILL_WAIT,   // Line read in flight
        ST_FILL_WRITE,
        ST_REPLAY
    } state_e;

    state_e                state;

    logic [TAG_BITS-1:0]   tag_arr [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_arr;
    logic [NUM_SETS-1:0]   dirty_arr;

    logic [INDEX_BITS-1:0] cur_index;
    logic [TAG_BITS-1:0]   cur_tag;
    logic                  accept;
    logic                  hit;
    logic                  victim_dirty;

    assign cur_index    = cur_req.addr.fld.index;
    assign cur_tag      = cur_req.addr.fld.tag;
    assign accept       = (state == ST_IDLE) && cpu_req_valid && (cpu_req.size != INVALID);
    assign hit          = valid_arr[cur_index] && (tag_arr[cur_index] == cur_tag);
    assign victim_dirty = valid_arr[cur_index] && dirty_arr[cur_index];

    // Bank read starts a cycle ahead of the lookup
    assign rd_index = (state == ST_IDLE) ? cpu_req.addr.fld.index : cur_index;

    // Store hit writes the bank at the end of the lookup cycle
    assign store_en = (state == ST_LOOKUP) && hit && cur_req.write;

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= cpu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FILL_WRITE) begin
            tag_arr[cur_index] <= cur_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FILL_WAIT && mem_resp_valid) begin
            fill_line <= mem_resp.rline;
        end
        if (state == ST_LOOKUP && hit) begin
            cpu_resp.rdata <= load_word;    // Undefined for stores
        end
    end

    // Memory request payload
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP && !hit) begin
            if (victim_dirty) begin
                mem_req.write     <= 1'b1;
                mem_req.line_addr <= {tag_arr[cur_index], cur_index};   // Evicted line
                mem_req.wline     <= bank_line;
            end else begin
                mem_req.write     <= 1'b0;
                mem_req.line_addr <= {cur_tag, cur_index};
            end
        end else if (state == ST_WB_WAIT && mem_resp_valid) begin
            mem_req.write     <= 1'b0;
            mem_req.line_addr <= {cur_tag, cur_index};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            busy           <= 1'b0;
            cpu_resp_valid <= 1'b0;
            mem_req_valid  <= 1'b0;
            fill_en        <= 1'b0;
            valid_arr      <= '0;
            dirty_arr      <= '0;
        end else begin
            cpu_resp_valid <= 1'b0;     // All strobes last one cycle
            mem_req_valid  <= 1'b0;
            fill_en        <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        busy  <= 1'b1;
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        if (cur_req.write) begin
                            dirty_arr[cur_index] <= 1'b1;
                        end
                        cpu_resp_valid <= 1'b1;
                        busy           <= 1'b0;
                        state          <= ST_IDLE;
                    end else begin
                        mem_req_valid <= 1'b1;
                        state         <= victim_dirty ? ST_WB_WAIT : ST_FILL_WAIT;
                    end
                end
                ST_WB_WAIT: begin
                    if (mem_resp_valid) begin
                        mem_req_valid <= 1'b1;  // Now the line read
                        state         <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (mem_resp_valid) begin
                        fill_en <= 1'b1;
                        state   <= ST_FILL_WRITE;
                    end
                end
                ST_FILL_WRITE: begin
                    valid_arr[cur_index] <= 1'b1;
                    dirty_arr[cur_index] <= 1'b0;
                    state                <= ST_REPLAY;
                end
                ST_REPLAY: begin
                    state <= ST_LOOKUP;     // Bank read of the filled line
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> !cpu_req_valid
    ) else $error("CPU request strobed while the cache is busy");

    // Memory answers at least a cycle after our request
    a_mem_resp_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> (state inside {ST_WB_WAIT, ST_FILL_WAIT}) && !mem_req_valid
    ) else $error("Memory response with no request in flight");

    a_store_fill_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(store_en && fill_en)
    ) else $error("Store and fill write the banks in the same cycle");

endmodule

/* cache_geom_pkg.sv */
package cache_geom_pkg;

    // Address split: | unused | tag | index | word | byte |
    localparam int OFFSET_BITS    = 4;
    localparam int INDEX_BITS     = 7;
    localparam int TAG_BITS       = 7;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS;  // Memory line address

    localparam int NUM_SETS       = 1 << INDEX_BITS;
    localparam int WORDS_PER_LINE = 4;
    localparam int BYTES_PER_WORD = 4;

    localparam int ADDR_BITS      = 32;
    localparam int UNUSED_BITS    = ADDR_BITS - LINE_ADDR_BITS - OFFSET_BITS;

    typedef logic [31:0] word_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;     // Word 0 in the low bits
    typedef logic [BYTES_PER_WORD-1:0] be_t;

    // Field view of a CPU address
    typedef struct packed {
        logic [UNUSED_BITS-1:0] unused;             // Ignored, addresses alias
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [1:0]             word_sel;           // Bank select
        logic [1:0]             byte_sel;
    } addr_fields_t;

    // Same 32 bits, read flat or split into fields
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        addr_fields_t         fld;
    } cpu_addr_u;

endpackage

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_req_valid,
    input  cache_bus_pkg::cpu_req_t  cpu_req,
    output logic                     cpu_resp_valid,
    output cache_bus_pkg::cpu_resp_t cpu_resp,
    output logic                     busy,
    output logic                     mem_req_valid,
    output cache_bus_pkg::mem_req_t  mem_req,
    input  logic                     mem_resp_valid,
    input  cache_bus_pkg::mem_resp_t mem_resp
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    logic [INDEX_BITS-1:0]      rd_index;
    logic [INDEX_BITS-1:0]      wr_index;
    cpu_req_t                   cur_req;
    logic                       store_en;
    logic                       fill_en;
    line_t                      fill_line;
    line_t                      bank_line;
    word_t                      load_word;

    logic [WORDS_PER_LINE-1:0]  bank_we;
    be_t [WORDS_PER_LINE-1:0]   bank_be;
    word_t [WORDS_PER_LINE-1:0] bank_wdata;
    word_t                      bank_rdata [WORDS_PER_LINE];

    cache_ctrl u_cache_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp       (cpu_resp),
        .busy           (busy),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp),
        .rd_index       (rd_index),
        .cur_req        (cur_req),
        .store_en       (store_en),
        .fill_en        (fill_en),
        .fill_line      (fill_line),
        .bank_line      (bank_line),
        .load_word      (load_word)
    );

    store_align u_store_align (
        .cur_req    (cur_req),
        .store_en   (store_en),
        .fill_en    (fill_en),
        .fill_line  (fill_line),
        .bank_we    (bank_we),
        .bank_be    (bank_be),
        .bank_wdata (bank_wdata),
        .wr_index   (wr_index)
    );

    // One bank per word of the line
    for (genvar g = 0; g < WORDS_PER_LINE; g++) begin : g_bank
        word_bank u_word_bank (
            .clk      (clk),
            .we       (bank_we[g]),
            .be       (bank_be[g]),
            .wdata    (bank_wdata[g]),
            .wr_index (wr_index),
            .rd_index (rd_index),
            .rdata    (bank_rdata[g])
        );
    end

    assign bank_line = {bank_rdata[3], bank_rdata[2], bank_rdata[1], bank_rdata[0]};

    load_align u_load_align (
        .cur_req   (cur_req),
        .bank_line (bank_line),
        .load_word (load_word)
    );

endmodule

/* load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  cache_bus_pkg::cpu_req_t cur_req,
    input  cache_geom_pkg::line_t   bank_line,
    output cache_geom_pkg::word_t   load_word
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    word_t      sel_word;
    logic [1:0] bsel;

    assign sel_word = bank_line[cur_req.addr.fld.word_sel];
    assign bsel     = cur_req.addr.fld.byte_sel;

    // Right-align and zero-extend, offset rounded down to the size
    always_comb begin
        case (cur_req.size)
            BYTE: begin
                load_word = {24'h0, sel_word[8*bsel +: 8]};
            end
            HALF: begin
                load_word = {16'h0, sel_word[16*bsel[1] +: 16]};
            end
            WORD: begin
                load_word = sel_word;
            end
            default: begin
                load_word = '0;     // Never accepted
            end
        endcase
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cache_top -f sim.f -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

/* sim.f */
cache_geom_pkg.sv
cache_bus_pkg.sv
word_bank.sv
store_align.sv
load_align.sv
cache_ctrl.sv
cache_top.sv
tb_cache_top.sv

/* store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  cache_bus_pkg::cpu_req_t                                     cur_req,
    input  logic                                                        store_en,
    input  logic                                                        fill_en,
    input  cache_geom_pkg::line_t                                       fill_line,
    output logic [cache_geom_pkg::WORDS_PER_LINE-1:0]                   bank_we,
    output cache_geom_pkg::be_t [cache_geom_pkg::WORDS_PER_LINE-1:0]    bank_be,
    output cache_geom_pkg::word_t [cache_geom_pkg::WORDS_PER_LINE-1:0]  bank_wdata,
    output logic [cache_geom_pkg::INDEX_BITS-1:0]                       wr_index
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    be_t        st_be;
    word_t      st_word;
    logic [1:0] wsel;
    logic [1:0] bsel;

    assign wr_index = cur_req.addr.fld.index;   // Fills go to the same set
    assign wsel     = cur_req.addr.fld.word_sel;
    assign bsel     = cur_req.addr.fld.byte_sel;

    // Offset rounded down to the access size, data copied to every lane
    always_comb begin
        case (cur_req.size)
            BYTE: begin
                st_be   = be_t'(4'b0001 << bsel);
                st_word = {4{cur_req.wdata[7:0]}};
            end
            HALF: begin
                st_be   = bsel[1] ? 4'b1100 : 4'b0011;
                st_word = {2{cur_req.wdata[15:0]}};
            end
            WORD: begin
                st_be   = 4'b1111;
                st_word = cur_req.wdata;
            end
            default: begin
                st_be   = 4'b0000;
                st_word = cur_req.wdata;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            bank_we[i]    = fill_en || (store_en && (wsel == 2'(i)));
            bank_be[i]    = fill_en ? 4'b1111 : st_be;
            bank_wdata[i] = fill_en ? fill_line[i] : st_word;
        end
    end

endmodule

/* tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int TIMEOUT = 200;

    logic      clk;
    logic      rst_n;
    logic      cpu_req_valid;
    cpu_req_t  cpu_req;
    logic      cpu_resp_valid;
    cpu_resp_t cpu_resp;
    logic      busy;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_resp_valid;
    mem_resp_t mem_resp;

    logic [7:0]  ref_mem [0:262143];    // Byte view of the 18-bit space
    logic [6:0]  sh_tag [NUM_SETS];
    bit   [NUM_SETS-1:0] sh_valid;
    bit   [NUM_SETS-1:0] sh_dirty;
    line_t       mem_store [int];       // Lines written back so far
    logic [6:0]  tag_pool [4] = '{7'h00, 7'h23, 7'h5c, 7'h7f};
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          start_err;
    bit          aborted;

    cache_top u_cache_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp       (cpu_resp),
        .busy           (busy),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Background contents, a hash of the word address
    function automatic word_t fill_word(input logic [15:0] waddr);
        return (32'(waddr) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic line_t memory_line(input logic [13:0] la);
        line_t l;
        if (mem_store.exists(int'(la))) begin
            return mem_store[int'(la)];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = fill_word({la, 2'(w)});
        end
        return l;
    endfunction

    function automatic line_t model_line(input logic [13:0] la);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                l[w][8*b +: 8] = ref_mem[{la, 2'(w), 2'(b)}];
            end
        end
        return l;
    endfunction

    function automatic logic [31:0] make_addr(input logic [6:0] tag, input logic [6:0] idx,
                                              input logic [3:0] off);
        return {14'h0, tag, idx, off};
    endfunction

    // One CPU access, with the memory answering any request on the way
    task automatic run_op(input logic [31:0] addr, input bit wr, input access_size_e size,
                          input word_t wdata);
        logic [17:0] a;
        logic [17:0] base;
        logic [6:0]  idx;
        logic [6:0]  tag;
        logic [13:0] wb_addr;
        logic [13:0] rd_addr;
        line_t       wb_line;
        line_t       resp_line;
        word_t       exp_load;
        bit          hit;
        bit          wb;
        bit          done;
        int          n_exp;
        int          n_seen;
        int          cycles;
        int          pending;
        int          nbytes;
        if (aborted) begin
            return;
        end
        a       = addr[17:0];
        idx     = a[10:4];
        tag     = a[17:11];
        hit     = sh_valid[idx] && (sh_tag[idx] == tag);
        wb      = !hit && sh_valid[idx] && sh_dirty[idx];
        wb_addr = {sh_tag[idx], idx};
        rd_addr = {tag, idx};
        wb_line = model_line(wb_addr);
        n_exp   = hit ? 0 : (wb ? 2 : 1);
        nbytes  = (size == WORD) ? 4 : int'(size);
        base    = a & ~18'(nbytes - 1);     // Round down to the size
        exp_load = '0;
        for (int k = 0; k < nbytes; k++) begin
            exp_load[8*k +: 8] = ref_mem[base + 18'(k)];
        end
        cpu_req.addr.raw = addr;
        cpu_req.write    = wr;
        cpu_req.size     = size;
        cpu_req.wdata    = wdata;
        cpu_req_valid    = 1'b1;
        n_seen  = 0;
        cycles  = 0;
        pending = 0;
        done    = 0;
        resp_line = '0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            cpu_req_valid  = 1'b0;
            mem_resp_valid = 1'b0;
            if (pending > 0) begin
                pending--;
                if (pending == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp.rline = resp_line;
                end
            end
            if (mem_req_valid) begin
                if (n_seen >= n_exp) begin
                    n_errors++;
                    $display("Unexpected memory request for line 0x%0h", mem_req.line_addr);
                end else if (wb && n_seen == 0) begin
                    check_val("mem_req.write", 128'(mem_req.write), 128'(1));
                    check_val("mem_req.line_addr", 128'(mem_req.line_addr), 128'(wb_addr));
                    check_val("mem_req.wline", mem_req.wline, wb_line);
                end else begin
                    check_val("mem_req.write", 128'(mem_req.write), 128'(0));
                    check_val("mem_req.line_addr", 128'(mem_req.line_addr), 128'(rd_addr));
                end
                n_seen++;
                if (mem_req.write) begin
                    mem_store[int'(mem_req.line_addr)] = mem_req.wline;
                    resp_line = '0;
                end else begin
                    resp_line = memory_line(mem_req.line_addr);
                end
                pending = int'($urandom_range(1, 8));
            end
            if (cpu_resp_valid) begin
                done = 1;
            end else begin
                check_val("busy", 128'(busy), 128'(1));     // High until the response
            end
        end
        if (!done) begin
            n_errors++;
            aborted = 1;
            $display("No response to the access at 0x%0h within %0d cycles", addr, TIMEOUT);
            return;
        end
        check_val("busy", 128'(busy), 128'(0));
        check_val("mem_req_count", 128'(n_seen), 128'(n_exp));
        if (hit) begin
            check_val("hit_latency", 128'(cycles), 128'(2));
        end
        if (!wr) begin
            check_val("cpu_resp.rdata", 128'(cpu_resp.rdata), 128'(exp_load));
        end else begin
            for (int k = 0; k < nbytes; k++) begin
                ref_mem[base + 18'(k)] = wdata[8*k +: 8];
            end
        end
        sh_dirty[idx] = (hit && sh_dirty[idx]) || wr;
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = tag;
    endtask

    task automatic random_op();
        logic [31:0] addr;
        addr = {14'($urandom), tag_pool[2'($urandom)], 7'($urandom_range(0, 31)), 4'($urandom)};
        run_op(addr, 1'($urandom), access_size_e'(2'($urandom_range(1, 3))), $urandom);
    endtask

    // Dropped requests, followed by loads of the same address
    task automatic invalid_ops();
        logic [31:0] addr;
        for (int n = 0; n < 10; n++) begin
            addr = {14'($urandom), tag_pool[2'($urandom)], 7'($urandom_range(0, 31)), 4'($urandom)};
            cpu_req.addr.raw = addr;
            cpu_req.write    = 1'b1;
            cpu_req.size     = INVALID;
            cpu_req.wdata    = $urandom;
            cpu_req_valid    = 1'b1;
            for (int c = 0; c < 20; c++) begin
                @(negedge clk);
                cpu_req_valid = 1'b0;
                check_val("busy", 128'(busy), 128'(0));
                check_val("cpu_resp_valid", 128'(cpu_resp_valid), 128'(0));
                check_val("mem_req_valid", 128'(mem_req_valid), 128'(0));
            end
            run_op(addr, 1'b0, WORD, '0);
            random_op();
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        n_tests++;
        $display("test %s finished with %0d errors", name, n_errors - first_err);
    endtask

    initial begin
        logic [31:0] base_a;
        logic [31:0] base_b;
        word_t       w;
        void'($urandom(32'hbccc_798e));
        clk            = 1'b0;
        rst_n          = 1'b0;
        cpu_req_valid  = 1'b0;
        cpu_req        = '0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        sh_valid       = '0;
        sh_dirty       = '0;
        for (int i = 0; i < 262144; i++) begin
            w          = fill_word(16'(i >> 2));
            ref_mem[i] = w[8*(i%4) +: 8];
        end

        start_err = n_errors;
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            check_val("busy", 128'(busy), 128'(0));
            check_val("cpu_resp_valid", 128'(cpu_resp_valid), 128'(0));
            check_val("mem_req_valid", 128'(mem_req_valid), 128'(0));
            if (c == 4) begin
                rst_n = 1'b1;   // Released after five cycles
            end
        end
        report_test("reset", start_err);

        start_err = n_errors;
        base_a = make_addr(7'h23, 7'd5, 4'd0);
        base_b = make_addr(7'h5c, 7'd5, 4'd4);
        run_op(base_a, 1'b0, WORD, '0);                     // Clean miss
        run_op(base_a + 32'd1, 1'b1, BYTE, 32'h1234_56a5);
        run_op(base_a + 32'd7, 1'b1, HALF, 32'hdead_beef);  // Lands on bytes 6 and 7
        run_op(base_a + 32'd8, 1'b1, WORD, 32'hcafe_f00d);
        run_op(base_a, 1'b0, WORD, '0);
        run_op(base_a + 32'd4, 1'b0, WORD, '0);
        run_op(base_a + 32'd11, 1'b0, WORD, '0);
        run_op(base_a + 32'd3, 1'b0, HALF, '0);
        run_op(base_a + 32'd1, 1'b0, BYTE, '0);
        run_op(base_b, 1'b1, BYTE, 32'h0000_0077);          // Store miss over a dirty line
        run_op(base_a + 32'd6, 1'b0, HALF, '0);             // Evicts the other dirty line
        report_test("directed", start_err);

        start_err = n_errors;
        for (int i = 0; i < 2000 && !aborted; i++) begin
            random_op();
        end
        report_test("random", start_err);

        start_err = n_errors;
        invalid_ops();
        report_test("invalid", start_err);

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* word_bank.sv */
`timescale 1ns/1ps

module word_bank (
    input  logic                                  clk,
    input  logic                                  we,
    input  cache_geom_pkg::be_t                   be,
    input  cache_geom_pkg::word_t                 wdata,
    input  logic [cache_geom_pkg::INDEX_BITS-1:0] wr_index,
    input  logic [cache_geom_pkg::INDEX_BITS-1:0] rd_index,
    output cache_geom_pkg::word_t                 rdata
);
    import cache_geom_pkg::*;

    word_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (be[b]) begin
                    mem[wr_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-index write
    always_ff @(posedge clk) begin
        rdata <= mem[rd_index];
    end

endmodule
